/* hw/wb_pkg.sv */
/*
 * Wishbone bus widths and slave address map for the control core.
 * Full 32-bit word accesses only, so there is no byte select.
 */

package wb_pkg;

   ////////////////////////////////////////////////////
   // Bus widths

   // Data width
   localparam int WB_DW = 32;
   // Byte address width, 64K byte space
   localparam int WB_AW = 16;
   // Top address bits used to pick a slave
   localparam int WB_DECODE_W = 6;

   ////////////////////////////////////////////////////
   // Slave map, compared against adr[15:10]

   localparam logic [WB_DECODE_W-1:0] SLV_SETTINGS_ADDR = 6'b110101;
   localparam logic [WB_DECODE_W-1:0] SLV_PIC_ADDR      = 6'b110110;
   localparam logic [WB_DECODE_W-1:0] SLV_STATUS_ADDR   = 6'b110011;

   // Decoded slave, NONE means unmapped
   typedef enum logic [1:0] {
      SLV_NONE,
      SLV_SETTINGS,
      SLV_PIC,
      SLV_STATUS
   } slave_e;

endpackage

/* hw/ctrl_pkg.sv */
/*
 * Register map of the control slaves: setting addresses, interrupt
 * controller words and readback words. Word index comes from adr[..:2].
 */

package ctrl_pkg;

   ////////////////////////////////////////////////////
   // Settings bus

   // Setting address width, byte address bits 9..2
   localparam int SET_AW = 8;
   // Width kept per setting register
   localparam int SET_REG_W = 8;

   // Setting register addresses
   typedef enum logic [SET_AW-1:0] {
      SR_CLK     = 8'd0,
      SR_SER     = 8'd1,
      SR_ADC     = 8'd2,
      SR_LED_SW  = 8'd3,
      SR_PHY     = 8'd4,
      SR_LED_SRC = 8'd8
   } set_addr_e;

   ////////////////////////////////////////////////////
   // Interrupt controller

   // Number of interrupt lines
   localparam int IRQ_W = 16;

   // Register select, adr[3:2]
   typedef enum logic [1:0] {
      PIC_MASK    = 2'd0,
      PIC_PENDING = 2'd1,
      PIC_CURRENT = 2'd2,
      PIC_HIGHEST = 2'd3
   } pic_reg_e;

   // HIGHEST readback when nothing is enabled and pending
   localparam logic [31:0] PIC_NONE = 32'hFFFF_FFFF;

   ////////////////////////////////////////////////////
   // Status readback words, adr[5:2]
   typedef enum logic [3:0] {
      RB_CYCLES = 4'd0,
      RB_CONFIG = 4'd1,
      RB_IRQ    = 4'd2
   } rb_word_e;

endpackage

/* hw/wb_decode.sv */
/*
 * Single master Wishbone decoder. Settings slave is write only and
 * reads as zero; unmapped addresses get a local ack with zero data.
 */
`timescale 1ns/1ps

module wb_decode (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     cyc_i,
   input  logic                     stb_i,
   input  logic [wb_pkg::WB_AW-1:0] adr_i,
   input  logic                     set_ack_i,
   input  logic                     pic_ack_i,
   input  logic [wb_pkg::WB_DW-1:0] pic_dat_i,
   input  logic                     rb_ack_i,
   input  logic [wb_pkg::WB_DW-1:0] rb_dat_i,
   output logic                     set_stb_o,
   output logic                     pic_stb_o,
   output logic                     rb_stb_o,
   output logic                     ack_o,
   output logic [wb_pkg::WB_DW-1:0] dat_o
);

   wb_pkg::slave_e slave;
   logic           acc;
   logic           none_ack;

   // Slave select from the top address bits
   always_comb begin
      case (adr_i[wb_pkg::WB_AW-1 -: wb_pkg::WB_DECODE_W])
         wb_pkg::SLV_SETTINGS_ADDR: slave = wb_pkg::SLV_SETTINGS;
         wb_pkg::SLV_PIC_ADDR:      slave = wb_pkg::SLV_PIC;
         wb_pkg::SLV_STATUS_ADDR:   slave = wb_pkg::SLV_STATUS;
         default:                   slave = wb_pkg::SLV_NONE;
      endcase
   end

   // Access in progress, stb only counts inside a cycle
   assign acc = cyc_i & stb_i;

   assign set_stb_o = acc & (slave == wb_pkg::SLV_SETTINGS);
   assign pic_stb_o = acc & (slave == wb_pkg::SLV_PIC);
   assign rb_stb_o  = acc & (slave == wb_pkg::SLV_STATUS);

   // Local ack for holes in the map, one pulse per held access
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= acc & (slave == wb_pkg::SLV_NONE) & ~none_ack;
      end
   end

   ////////////////////////////////////////////////////
   // Return path
   always_comb begin
      case (slave)
         wb_pkg::SLV_SETTINGS: begin
            ack_o = set_ack_i;
            dat_o = '0;
         end
         wb_pkg::SLV_PIC: begin
            ack_o = pic_ack_i;
            dat_o = pic_dat_i;
         end
         wb_pkg::SLV_STATUS: begin
            ack_o = rb_ack_i;
            dat_o = rb_dat_i;
         end
         default: begin
            ack_o = none_ack;
            dat_o = '0;
         end
      endcase
   end

   // Any slave ack must land while the master still strobes
   a_ack_in_stb: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      ack_o |-> stb_i);

endmodule

/* hw/settings_bus.sv */
/*
 * Turns Wishbone writes into one-cycle setting strobes.
 * Reads are acked with no data; only adr[9:2] reaches the setting bank.
 */
`timescale 1ns/1ps

module settings_bus (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [wb_pkg::WB_AW-1:0]    adr_i,
   input  logic [wb_pkg::WB_DW-1:0]    dat_i,
   output logic                        ack_o,
   output logic                        set_stb_o,
   output logic [ctrl_pkg::SET_AW-1:0] set_addr_o,
   output logic [wb_pkg::WB_DW-1:0]    set_data_o
);

   // Ack and strobe together, ack drops while stb is still held
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= stb_i & ~ack_o;
         set_stb_o <= stb_i & we_i & ~ack_o;
      end
   end

   // Word address and payload
   always_ff @(posedge dsp_clk) begin
      if (stb_i & we_i & ~ack_o) begin
         set_addr_o <= adr_i[ctrl_pkg::SET_AW+1:2];
         set_data_o <= dat_i;
      end
   end

   // One held write gives exactly one strobe
   a_set_stb_pulse: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_stb_o |=> !set_stb_o);

endmodule

/* hw/setting_bank.sv */
/*
 * Setting registers behind the settings bus and the board control
 * lines taken from them. Only the low 8 data bits are kept per register.
 */
`timescale 1ns/1ps

module setting_bank (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  logic                        set_stb_i,
   input  logic [ctrl_pkg::SET_AW-1:0] set_addr_i,
   input  logic [wb_pkg::WB_DW-1:0]    set_data_i,
   input  logic                        clk_status_i,
   input  logic                        link_up_i,
   output logic                        clock_ready_o,
   output logic [1:0]                  clk_en_o,
   output logic [1:0]                  clk_sel_o,
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,
   output logic                        adc_oe_a_o,
   output logic                        adc_on_a_o,
   output logic                        adc_oe_b_o,
   output logic                        adc_on_b_o,
   output logic                        phy_reset_n_o,
   output logic [7:0]                  leds_o
);

   ctrl_pkg::set_addr_e            addr_sel;
   logic [ctrl_pkg::SET_REG_W-1:0] clk_reg;
   logic [ctrl_pkg::SET_REG_W-1:0] ser_reg;
   logic [ctrl_pkg::SET_REG_W-1:0] adc_reg;
   logic [ctrl_pkg::SET_REG_W-1:0] led_sw_reg;
   logic [ctrl_pkg::SET_REG_W-1:0] phy_reg;
   logic [ctrl_pkg::SET_REG_W-1:0] led_src_reg;
   logic [7:0]                     led_hw;

   assign addr_sel = ctrl_pkg::set_addr_e'(set_addr_i);

   ////////////////////////////////////////////////////
   // Register load, unknown addresses fall through
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_reg     <= '0;
         ser_reg     <= '0;
         adc_reg     <= '0;
         led_sw_reg  <= '0;
         phy_reg     <= '0;
         led_src_reg <= '0;
      end else if (set_stb_i) begin
         case (addr_sel)
            ctrl_pkg::SR_CLK:     clk_reg     <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            ctrl_pkg::SR_SER:     ser_reg     <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            ctrl_pkg::SR_ADC:     adc_reg     <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            ctrl_pkg::SR_LED_SW:  led_sw_reg  <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            ctrl_pkg::SR_PHY:     phy_reg     <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            ctrl_pkg::SR_LED_SRC: led_src_reg <= set_data_i[ctrl_pkg::SET_REG_W-1:0];
            default: ;
         endcase
      end
   end

   // Clock generator, SERDES and ADC control bits
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_reg[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_reg[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_reg[3:0];

   // PHY held out of reset while the bit is clear
   assign phy_reset_n_o = ~phy_reg[0];

   // LEDs, a 1 in the source register selects the hardware value
   assign led_hw = {6'b0, clk_status_i, link_up_i};
   assign leds_o = (led_src_reg & led_hw) | (~led_src_reg & led_sw_reg);

endmodule

/* hw/pic.sv */
/*
 * Interrupt controller with rising-edge capture, mask and write-one-to-clear.
 * An edge in the same cycle as a clear wins. Lowest index has priority.
 */
`timescale 1ns/1ps

module pic (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [wb_pkg::WB_AW-1:0]    adr_i,
   input  logic [wb_pkg::WB_DW-1:0]    dat_i,
   input  logic [ctrl_pkg::IRQ_W-1:0]  irq_i,
   output logic                        ack_o,
   output logic [wb_pkg::WB_DW-1:0]    dat_o,
   output logic                        int_o
);

   ctrl_pkg::pic_reg_e             reg_sel;
   logic                           wr;
   logic [ctrl_pkg::IRQ_W-1:0]     irq_d;
   logic [ctrl_pkg::IRQ_W-1:0]     irq_rise;
   logic [ctrl_pkg::IRQ_W-1:0]     mask_q;
   logic [wb_pkg::WB_DW-1:0]       pending_q;
   logic [wb_pkg::WB_DW-1:0]       clr;
   logic [ctrl_pkg::IRQ_W-1:0]     active;
   logic [wb_pkg::WB_DW-1:0]       highest;
   logic [wb_pkg::WB_DW-1:0]       rd_data;

   assign reg_sel = ctrl_pkg::pic_reg_e'(adr_i[3:2]);
   // Single write per held access
   assign wr = stb_i & we_i & ~ack_o;

   assign irq_rise = irq_i & ~irq_d;
   assign clr = (wr && reg_sel == ctrl_pkg::PIC_PENDING) ? dat_i : '0;

   ////////////////////////////////////////////////////
   // Edge capture, mask and bus ack
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o     <= 1'b0;
         irq_d     <= '0;
         mask_q    <= '0;
         pending_q <= '0;
      end else begin
         ack_o     <= stb_i & ~ack_o;
         irq_d     <= irq_i;
         pending_q <= (pending_q & ~clr) | wb_pkg::WB_DW'(irq_rise);
         if (wr && reg_sel == ctrl_pkg::PIC_MASK) begin
            mask_q <= dat_i[ctrl_pkg::IRQ_W-1:0];
         end
      end
   end

   assign active = pending_q[ctrl_pkg::IRQ_W-1:0] & mask_q;
   assign int_o  = |active;

   // Lowest enabled pending line wins
   always_comb begin
      highest = ctrl_pkg::PIC_NONE;
      for (int i = ctrl_pkg::IRQ_W-1; i >= 0; i--) begin
         if (active[i]) highest = wb_pkg::WB_DW'(i);
      end
   end

   always_comb begin
      case (reg_sel)
         ctrl_pkg::PIC_MASK:    rd_data = wb_pkg::WB_DW'(mask_q);
         ctrl_pkg::PIC_PENDING: rd_data = pending_q;
         ctrl_pkg::PIC_CURRENT: rd_data = wb_pkg::WB_DW'(irq_i);
         default:               rd_data = highest;
      endcase
   end

   // Read word captured with the ack
   always_ff @(posedge dsp_clk) begin
      dat_o <= rd_data;
   end

   // Pending bits stay within the interrupt lines
   a_pending_in_range: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      pending_q[wb_pkg::WB_DW-1:ctrl_pkg::IRQ_W] == '0);

endmodule

/* hw/status_readback.sv */
/*
 * Read-only status words: free-running cycle counter, configuration
 * straps and the raw interrupt lines. Writes are acked and dropped.
 */
`timescale 1ns/1ps

module status_readback (
   input  logic                       dsp_clk,
   input  logic                       wb_rst,
   input  logic                       stb_i,
   input  logic [wb_pkg::WB_AW-1:0]   adr_i,
   input  logic [ctrl_pkg::IRQ_W-1:0] irq_i,
   input  logic                       sim_mode_i,
   input  logic [3:0]                 clock_divider_i,
   output logic                       ack_o,
   output logic [wb_pkg::WB_DW-1:0]   dat_o
);

   ctrl_pkg::rb_word_e       word_sel;
   logic [31:0]              cycle_cnt;
   logic [wb_pkg::WB_DW-1:0] rd_data;

   assign word_sel = ctrl_pkg::rb_word_e'(adr_i[5:2]);

   // Cycle counter and ack
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
         ack_o     <= 1'b0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;
         ack_o     <= stb_i & ~ack_o;
      end
   end

   always_comb begin
      case (word_sel)
         ctrl_pkg::RB_CYCLES: rd_data = cycle_cnt;
         ctrl_pkg::RB_CONFIG: rd_data = {sim_mode_i, 27'b0, clock_divider_i};
         ctrl_pkg::RB_IRQ:    rd_data = wb_pkg::WB_DW'(irq_i);
         default:             rd_data = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      dat_o <= rd_data;
   end

endmodule

/* hw/u2_ctrl_core.sv */
/*
 * Control-plane core: one Wishbone classic slave port, single clock.
 * Every access is a full word and completes in two cycles.
 */
`timescale 1ns/1ps

module u2_ctrl_core (
   input  logic                       dsp_clk,
   input  logic                       wb_rst,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [wb_pkg::WB_AW-1:0]   wb_adr_i,
   input  logic [wb_pkg::WB_DW-1:0]   wb_dat_i,
   input  logic [ctrl_pkg::IRQ_W-1:0] irq_i,
   input  logic                       clk_status_i,
   input  logic                       link_up_i,
   input  logic                       sim_mode_i,
   input  logic [3:0]                 clock_divider_i,
   output logic [wb_pkg::WB_DW-1:0]   wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       int_o,
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output logic [7:0]                 leds_o
);

   logic                        set_wb_stb, set_wb_ack;
   logic                        pic_stb, pic_ack;
   logic                        rb_stb, rb_ack;
   logic [wb_pkg::WB_DW-1:0]    pic_dat, rb_dat;
   logic                        set_stb;
   logic [ctrl_pkg::SET_AW-1:0] set_addr;
   logic [wb_pkg::WB_DW-1:0]    set_data;

   ////////////////////////////////////////////////////
   // Address decode
   wb_decode i_wb_decode (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .adr_i(wb_adr_i), .set_ack_i(set_wb_ack), .pic_ack_i(pic_ack), .pic_dat_i(pic_dat),
      .rb_ack_i(rb_ack), .rb_dat_i(rb_dat), .set_stb_o(set_wb_stb), .pic_stb_o(pic_stb),
      .rb_stb_o(rb_stb), .ack_o(wb_ack_o), .dat_o(wb_dat_o));

   // Settings bus and the register bank behind it
   settings_bus i_settings_bus (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .stb_i(set_wb_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i), .ack_o(set_wb_ack), .set_stb_o(set_stb),
      .set_addr_o(set_addr), .set_data_o(set_data));

   setting_bank i_setting_bank (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o), .adc_oe_b_o(adc_oe_b_o),
      .adc_on_b_o(adc_on_b_o), .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   ////////////////////////////////////////////////////
   // Interrupts and status
   pic i_pic (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .stb_i(pic_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i), .irq_i(irq_i), .ack_o(pic_ack),
      .dat_o(pic_dat), .int_o(int_o));

   status_readback i_status_readback (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .stb_i(rb_stb), .adr_i(wb_adr_i),
      .irq_i(irq_i), .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .ack_o(rb_ack), .dat_o(rb_dat));

endmodule

/* tests/tb_u2_ctrl_core.sv */
/*
 * Testbench for the control core. One full-word Wishbone access at a time.
 * The irq lines stay steady across a pending clear so no edge races the clear.
 */
`timescale 1ns/1ps

module tb_u2_ctrl_core;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   localparam int DRIVE_DLY    = 2;
   localparam int ACK_TIMEOUT  = 16;
   localparam int N_SET_ITER   = 24;
   localparam int N_LED_ITER   = 16;
   localparam int N_IRQ_ITER   = 20;
   // Worst case bus accesses over all tests
   localparam int N_ACCESSES   = N_SET_ITER + 6 + 3 + 2*N_LED_ITER + 1 + 7*N_IRQ_ITER + 6;
   localparam int WATCHDOG_NS  = (N_ACCESSES*10 + RESET_CYCLES + 50) * CLK_PERIOD;

   logic                             dsp_clk;
   logic                             wb_rst;
   logic                             wb_cyc, wb_stb, wb_we, wb_ack;
   logic [wb_pkg::WB_AW-1:0]         wb_adr;
   logic [wb_pkg::WB_DW-1:0]         wb_dat_w, wb_dat_r;
   logic [ctrl_pkg::IRQ_W-1:0]       irq;
   logic                             clk_status, link_up, sim_mode, int_o;
   logic [3:0]                       clock_divider;
   logic                             clock_ready, phy_reset_n;
   logic [1:0]                       clk_en, clk_sel;
   logic                             ser_enable, ser_prbsen, ser_loopen, ser_rx_en;
   logic                             adc_oe_a, adc_on_a, adc_oe_b, adc_on_b;
   logic [7:0]                       leds;
   logic [21:0]                      ctrl_now;

   // Expected state built from the writes issued so far
   logic [7:0]                       shadow_reg [0:15];
   logic [ctrl_pkg::IRQ_W-1:0]       exp_mask;
   logic [31:0]                      exp_pending;
   int set_addrs [0:5] = '{ctrl_pkg::SR_CLK, ctrl_pkg::SR_SER, ctrl_pkg::SR_ADC,
                           ctrl_pkg::SR_LED_SW, ctrl_pkg::SR_PHY, ctrl_pkg::SR_LED_SRC};
   int unused_addrs [0:5] = '{5, 6, 7, 9, 12, 200};
   int err_cnt  = 0;
   int chk_cnt  = 0;
   int test_cnt = 0;
   event compare_ev;

   u2_ctrl_core i_u2_ctrl_core (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .irq_i(irq),
      .clk_status_i(clk_status), .link_up_i(link_up), .sim_mode_i(sim_mode),
      .clock_divider_i(clock_divider), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .int_o(int_o), .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen), .ser_loopen_o(ser_loopen),
      .ser_rx_en_o(ser_rx_en), .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b), .phy_reset_n_o(phy_reset_n),
      .leds_o(leds));

   assign ctrl_now = {clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen,
                      ser_rx_en, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_reset_n, leds};

   initial dsp_clk = 1'b0;
   always #(CLK_PERIOD/2) dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////
   // Reference model

   // Control lines and LEDs in the packing of ctrl_now
   function automatic logic [21:0] ref_ctrl(input logic [7:0] r_clk, input logic [7:0] r_ser,
         input logic [7:0] r_adc, input logic [7:0] r_phy, input logic [7:0] r_sw,
         input logic [7:0] r_src, input logic hw_clk, input logic hw_link);
      logic [7:0] hw;
      logic [7:0] led;
      hw = 8'b0;
      hw[1] = hw_clk;
      hw[0] = hw_link;
      // Per-bit source choice
      for (int i = 0; i < 8; i++) begin
         led[i] = r_src[i] ? hw[i] : r_sw[i];
      end
      return {r_clk[4], r_clk[3:2], r_clk[1:0], r_ser[3], r_ser[2], r_ser[1], r_ser[0],
              r_adc[3], r_adc[2], r_adc[1], r_adc[0], ~r_phy[0], led};
   endfunction

   // Lowest enabled pending index or PIC_NONE
   function automatic logic [31:0] ref_highest(input logic [31:0] pend,
         input logic [ctrl_pkg::IRQ_W-1:0] mask);
      logic        found;
      logic [31:0] idx;
      found = 1'b0;
      idx = ctrl_pkg::PIC_NONE;
      for (int i = 0; i < ctrl_pkg::IRQ_W; i++) begin
         if (!found && pend[i] && mask[i]) begin
            idx = i;
            found = 1'b1;
         end
      end
      return idx;
   endfunction

   function automatic logic [15:0] slave_addr(input logic [5:0] slv, input int word);
      return {slv, word[7:0], 2'b00};
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
         input string what);
      chk_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   // Compare at the falling edge where outputs have settled
   always begin
      @(compare_ev);
      check({10'b0, ctrl_now}, {10'b0, ref_ctrl(shadow_reg[ctrl_pkg::SR_CLK],
            shadow_reg[ctrl_pkg::SR_SER], shadow_reg[ctrl_pkg::SR_ADC],
            shadow_reg[ctrl_pkg::SR_PHY], shadow_reg[ctrl_pkg::SR_LED_SW],
            shadow_reg[ctrl_pkg::SR_LED_SRC], clk_status, link_up)}, "control lines and LEDs");
      check({31'b0, int_o}, {31'b0, |(exp_pending[ctrl_pkg::IRQ_W-1:0] & exp_mask)},
            "interrupt output");
   end

   ////////////////////////////////////////////////////
   // Bus and stimulus tasks

   // Starts just after a rising edge and ends just after the edge that follows ack
   task automatic bus_access(input logic [15:0] addr, input logic we,
         input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      waited = 0;
      rdata = '0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = addr;
      wb_dat_w = wdata;
      @(negedge dsp_clk);
      while (!wb_ack && waited < ACK_TIMEOUT) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (wb_ack) begin
         rdata = wb_dat_r;
      end else begin
         err_cnt++;
         $display("Bus access to address %h was never acknowledged", addr);
      end
      @(posedge dsp_clk);
      #DRIVE_DLY;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(addr, 1'b1, data, unused);
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
      bus_access(addr, 1'b0, 32'h0, data);
   endtask

   task automatic sync_compare();
      @(negedge dsp_clk);
      -> compare_ev;
      @(posedge dsp_clk);
      #DRIVE_DLY;
   endtask

   // A 0 to 1 change on a line sets pending at the next edge
   task automatic set_irq(input logic [ctrl_pkg::IRQ_W-1:0] value);
      exp_pending = exp_pending | {16'b0, value & ~irq};
      irq = value;
      @(posedge dsp_clk);
      #DRIVE_DLY;
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, err_cnt - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////
   // Test sequence
   initial begin : stimulus
      int unsigned seed;
      int          errs_before;
      int          a;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic [31:0] rdata2;
      logic [15:0] set_base_unused;
      seed = 32'hfad3_7993;
      void'($urandom(seed));
      wb_rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      irq = '0;
      clk_status = 1'b0;
      link_up = 1'b0;
      sim_mode = 1'b0;
      clock_divider = 4'h0;
      exp_mask = '0;
      exp_pending = '0;
      for (int i = 0; i < 16; i++) begin
         shadow_reg[i] = 8'h00;
      end
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #DRIVE_DLY;
      wb_rst = 1'b0;

      // Reset state
      errs_before = err_cnt;
      sync_compare();
      check({31'b0, phy_reset_n}, 32'd1, "PHY reset released after reset");
      check({24'b0, leds}, 32'd0, "LEDs dark after reset");
      end_test("reset_state", errs_before);

      // Setting registers then unused addresses and reads
      errs_before = err_cnt;
      for (int n = 0; n < N_SET_ITER; n++) begin
         a = set_addrs[n % 6];
         wdata = $urandom;
         bus_write(slave_addr(wb_pkg::SLV_SETTINGS_ADDR, a), wdata);
         shadow_reg[a] = wdata[7:0];
         sync_compare();
      end
      for (int n = 0; n < 6; n++) begin
         bus_write(slave_addr(wb_pkg::SLV_SETTINGS_ADDR, unused_addrs[n]), $urandom);
         sync_compare();
      end
      for (int n = 0; n < 3; n++) begin
         bus_read(slave_addr(wb_pkg::SLV_SETTINGS_ADDR, set_addrs[n]), rdata);
         check(rdata, 32'h0, "settings slave read");
      end
      end_test("setting_registers", errs_before);

      // LED source select
      errs_before = err_cnt;
      for (int n = 0; n < N_LED_ITER; n++) begin
         wdata = $urandom;
         bus_write(slave_addr(wb_pkg::SLV_SETTINGS_ADDR, ctrl_pkg::SR_LED_SRC), wdata);
         shadow_reg[ctrl_pkg::SR_LED_SRC] = wdata[7:0];
         wdata = $urandom;
         bus_write(slave_addr(wb_pkg::SLV_SETTINGS_ADDR, ctrl_pkg::SR_LED_SW), wdata);
         shadow_reg[ctrl_pkg::SR_LED_SW] = wdata[7:0];
         clk_status = $urandom_range(1, 0);
         link_up = $urandom_range(1, 0);
         sync_compare();
      end
      end_test("led_source", errs_before);

      // Interrupt controller
      errs_before = err_cnt;
      wdata = $urandom;
      bus_write(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_MASK), wdata);
      exp_mask = wdata[ctrl_pkg::IRQ_W-1:0];
      for (int n = 0; n < N_IRQ_ITER; n++) begin
         if (n % 5 == 4) begin
            wdata = $urandom;
            bus_write(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_MASK), wdata);
            exp_mask = wdata[ctrl_pkg::IRQ_W-1:0];
         end
         wdata = $urandom;
         set_irq(wdata[ctrl_pkg::IRQ_W-1:0]);
         sync_compare();
         bus_read(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_MASK), rdata);
         check(rdata, {16'b0, exp_mask}, "interrupt mask");
         bus_read(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_PENDING), rdata);
         check(rdata, exp_pending, "pending after edges");
         bus_read(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_CURRENT), rdata);
         check(rdata, {16'b0, irq}, "raw interrupt lines");
         bus_read(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_HIGHEST), rdata);
         check(rdata, ref_highest(exp_pending, exp_mask), "highest pending");
         // Write one to clear
         wdata = $urandom;
         bus_write(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_PENDING), wdata);
         exp_pending = exp_pending & ~wdata;
         bus_read(slave_addr(wb_pkg::SLV_PIC_ADDR, ctrl_pkg::PIC_PENDING), rdata);
         check(rdata, exp_pending, "pending after clear");
         sync_compare();
      end
      end_test("interrupts", errs_before);

      // Status readback and unmapped space
      errs_before = err_cnt;
      sim_mode = $urandom_range(1, 0);
      wdata = $urandom;
      clock_divider = wdata[3:0];
      bus_read(slave_addr(wb_pkg::SLV_STATUS_ADDR, ctrl_pkg::RB_CONFIG), rdata);
      check(rdata, {sim_mode, 27'b0, clock_divider}, "configuration word");
      bus_read(slave_addr(wb_pkg::SLV_STATUS_ADDR, ctrl_pkg::RB_IRQ), rdata);
      check(rdata, {16'b0, irq}, "readback interrupt lines");
      bus_read(slave_addr(wb_pkg::SLV_STATUS_ADDR, ctrl_pkg::RB_CYCLES), rdata);
      bus_read(slave_addr(wb_pkg::SLV_STATUS_ADDR, ctrl_pkg::RB_CYCLES), rdata2);
      check({31'b0, rdata2 > rdata}, 32'd1, "cycle counter increases");
      bus_read(slave_addr(wb_pkg::SLV_STATUS_ADDR, 5), rdata);
      check(rdata, 32'h0, "unused status word");
      set_base_unused = slave_addr(6'b000000, 3);
      bus_read(set_base_unused, rdata);
      check(rdata, 32'h0, "unmapped address read");
      end_test("readback", errs_before);

      $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Bound from the access count of all tests
   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* u2_ctrl_core.f */
hw/wb_pkg.sv
hw/ctrl_pkg.sv
hw/wb_decode.sv
hw/settings_bus.sv
hw/setting_bank.sv
hw/pic.sv
hw/status_readback.sv
hw/u2_ctrl_core.sv
tests/tb_u2_ctrl_core.sv
